//--- src/sat_pkg.sv
package sat_pkg;

    // literal state reported by each slot of a clause row
    localparam logic [1:0] LS_FREE   = 2'b00;
    localparam logic [1:0] LS_TRUE   = 2'b01;
    localparam logic [1:0] LS_FALSE  = 2'b10;
    // slot not part of the clause, ignored by the row reduction
    localparam logic [1:0] LS_ABSENT = 2'b11;

    // default sizes for the top level parameters
    localparam int DEF_NUM_VARS    = 16;
    localparam int DEF_NUM_CLAUSES = 8;
    localparam int DEF_MAX_LEN     = 4;
    localparam int DEF_WIDTH_LVL   = 8;

endpackage

//--- src/var_state_if.sv
// current variable assignment, held by the assignment table
interface var_state_if import sat_pkg::*; #(
    parameter int NUM_VARS  = DEF_NUM_VARS,
    parameter int WIDTH_LVL = DEF_WIDTH_LVL
);
    logic [NUM_VARS-1:0]                assigned;
    logic [NUM_VARS-1:0]                value;
    logic [NUM_VARS-1:0][WIDTH_LVL-1:0] level;
    // a variable was unassigned at the last edge
    logic                               clearing;

    modport tbl (
        output assigned,
        output value,
        output level,
        output clearing
    );

    modport reader (
        input assigned,
        input value,
        input level,
        input clearing
    );
endinterface

// registered per clause classification
interface clause_status_if import sat_pkg::*; #(
    parameter int NUM_CLAUSES = DEF_NUM_CLAUSES,
    parameter int WIDTH_LVL   = DEF_WIDTH_LVL
);
    logic [NUM_CLAUSES-1:0]                sat;
    logic [NUM_CLAUSES-1:0]                unit;
    logic [NUM_CLAUSES-1:0]                conflict;
    logic [NUM_CLAUSES-1:0][WIDTH_LVL-1:0] lvl;

    modport row (
        output sat,
        output unit,
        output conflict,
        output lvl
    );

    modport report (
        input sat,
        input unit,
        input conflict,
        input lvl
    );
endinterface

//--- src/assign_table.sv
module assign_table #(
    parameter int NUM_VARS  = 16,
    parameter int WIDTH_LVL = 8,
    localparam int VAR_W    = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 asg_valid_i,
    input  logic [VAR_W-1:0]     asg_var_i,
    input  logic                 asg_val_i,
    input  logic [WIDTH_LVL-1:0] asg_lvl_i,
    input  logic                 asg_clear_i,

    var_state_if.tbl             vs
);

    // assigned flag and decision level per variable
    always_ff @(posedge clk) begin
        if (!rst) begin
            vs.assigned <= '0;
            vs.level    <= '0;
        end else begin
            for (int v = 0; v < NUM_VARS; v++) begin
                if (asg_valid_i && asg_var_i == VAR_W'(v)) begin
                    if (asg_clear_i) begin
                        // backtrack drops the variable back to level zero
                        vs.assigned[v] <= 1'b0;
                        vs.level[v]    <= '0;
                    end else begin
                        vs.assigned[v] <= 1'b1;
                        vs.level[v]    <= asg_lvl_i;
                    end
                end
            end
        end
    end

    // value only matters while assigned
    always_ff @(posedge clk) begin
        for (int v = 0; v < NUM_VARS; v++) begin
            if (asg_valid_i && !asg_clear_i && asg_var_i == VAR_W'(v)) begin
                vs.value[v] <= asg_val_i;
            end
        end
    end

    // one cycle marker of a backtrack step
    always_ff @(posedge clk) begin
        if (!rst) begin
            vs.clearing <= 1'b0;
        end else begin
            vs.clearing <= asg_valid_i && asg_clear_i;
        end
    end

    a_var_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        asg_valid_i |-> (asg_var_i < NUM_VARS)
    ) else $error("assignment to variable %0d out of range", asg_var_i);

endmodule

//--- src/lit_cell.sv
module lit_cell import sat_pkg::*; #(
    parameter int NUM_VARS  = 16,
    parameter int WIDTH_LVL = 8,
    localparam int VAR_W    = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 ld_we_i,
    input  logic [VAR_W-1:0]     ld_var_i,
    input  logic                 ld_pol_i,
    input  logic                 ld_en_i,

    var_state_if.reader          vs,

    output logic [1:0]           lit_state_o,
    output logic [WIDTH_LVL-1:0] lit_lvl_o
);

    logic             en_q;
    logic [VAR_W-1:0] var_q;
    logic             pol_q;

    // slot enable, cleared on reset so every clause starts empty
    always_ff @(posedge clk) begin
        if (!rst) begin
            en_q <= 1'b0;
        end else if (ld_we_i) begin
            en_q <= ld_en_i;
        end
    end

    // literal payload
    always_ff @(posedge clk) begin
        if (ld_we_i) begin
            var_q <= ld_var_i;
            pol_q <= ld_pol_i;
        end
    end

    // classify against the current assignment
    always_comb begin
        lit_lvl_o = vs.level[var_q];
        if (!en_q) begin
            lit_state_o = LS_ABSENT;
        end else if (!vs.assigned[var_q]) begin
            lit_state_o = LS_FREE;
        end else if (vs.value[var_q] == pol_q) begin
            lit_state_o = LS_TRUE;
        end else begin
            lit_state_o = LS_FALSE;
        end
    end

    // a false literal turns free again only through a backtrack step
    a_free_after_clear: assert property (
        @(posedge clk) disable iff (!rst)
        ($past(rst) && !$past(ld_we_i) && $past(lit_state_o) == LS_FALSE
            && lit_state_o == LS_FREE) |-> vs.clearing
    ) else $error("literal became free without a clear");

endmodule

//--- src/terminal_cell.sv
module terminal_cell #(
    parameter int WIDTH_LVL   = 8,
    parameter int WIDTH_C_LEN = 3
) (
    input  logic                   csat_i,
    input  logic [1:0]             freelitcnt_i,
    input  logic [WIDTH_C_LEN-1:0] clause_len_i,
    input  logic                   all_lit_false_i,
    input  logic [WIDTH_LVL-1:0]   cmax_lvl_i,

    output logic                   csat_o,
    output logic                   unit_o,
    output logic                   conflict_o,
    output logic [WIDTH_LVL-1:0]   cmax_lvl_o
);

    assign csat_o = csat_i;

    // one free literal left and nothing true yet
    assign unit_o = !csat_i && (freelitcnt_i == 2'b01);

    // an empty clause is never a conflict
    assign conflict_o = all_lit_false_i && (clause_len_i != '0);

    assign cmax_lvl_o = cmax_lvl_i;

endmodule

//--- src/clause_row.sv
module clause_row import sat_pkg::*; #(
    parameter int NUM_VARS    = 16,
    parameter int NUM_CLAUSES = 8,
    parameter int MAX_LEN     = 4,
    parameter int WIDTH_LVL   = 8,
    parameter int ROW_ID      = 0,
    localparam int VAR_W      = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1,
    localparam int CID_W      = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1,
    localparam int SLOT_W     = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
    localparam int LEN_W      = $clog2(MAX_LEN + 1)
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              ld_valid_i,
    input  logic [CID_W-1:0]  ld_cid_i,
    input  logic [SLOT_W-1:0] ld_slot_i,
    input  logic [VAR_W-1:0]  ld_var_i,
    input  logic              ld_pol_i,
    input  logic              ld_en_i,

    var_state_if.reader       vs,
    clause_status_if.row      st
);

    logic                 row_sel;
    logic [1:0]           lit_state [MAX_LEN];
    logic [WIDTH_LVL-1:0] lit_lvl   [MAX_LEN];

    logic                 csat;
    logic [1:0]           free_cnt;
    logic                 all_false;
    logic [LEN_W-1:0]     len;
    logic [WIDTH_LVL-1:0] max_lvl;

    logic                 t_sat;
    logic                 t_unit;
    logic                 t_conf;
    logic [WIDTH_LVL-1:0] t_lvl;

    logic                 sat_q;
    logic                 unit_q;
    logic                 conf_q;
    logic [WIDTH_LVL-1:0] lvl_q;

    assign row_sel = ld_valid_i && (ld_cid_i == CID_W'(ROW_ID));

    for (genvar k = 0; k < MAX_LEN; k++) begin : g_slot
        logic slot_hit;
        assign slot_hit = (ld_slot_i == SLOT_W'(k));

        // slot 0 load empties the whole row before writing
        lit_cell #(
            .NUM_VARS  (NUM_VARS),
            .WIDTH_LVL (WIDTH_LVL)
        ) i_lit_cell (
            .clk         (clk),
            .rst         (rst),
            .ld_we_i     (row_sel && (slot_hit || ld_slot_i == '0)),
            .ld_var_i    (ld_var_i),
            .ld_pol_i    (ld_pol_i),
            .ld_en_i     (slot_hit && ld_en_i),
            .vs          (vs),
            .lit_state_o (lit_state[k]),
            .lit_lvl_o   (lit_lvl[k])
        );
    end

    // reduce the slot states
    always_comb begin
        csat      = 1'b0;
        free_cnt  = 2'd0;
        all_false = 1'b1;
        len       = '0;
        max_lvl   = '0;
        for (int k = 0; k < MAX_LEN; k++) begin
            if (lit_state[k] != LS_ABSENT) begin
                len = len + LEN_W'(1);
            end
            case (lit_state[k])
                LS_TRUE: begin
                    csat      = 1'b1;
                    all_false = 1'b0;
                end
                LS_FREE: begin
                    all_false = 1'b0;
                    // two means two or more
                    if (free_cnt != 2'd2) begin
                        free_cnt = free_cnt + 2'd1;
                    end
                end
                LS_FALSE: begin
                    if (lit_lvl[k] > max_lvl) begin
                        max_lvl = lit_lvl[k];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    terminal_cell #(
        .WIDTH_LVL   (WIDTH_LVL),
        .WIDTH_C_LEN (LEN_W)
    ) i_terminal_cell (
        .csat_i          (csat),
        .freelitcnt_i    (free_cnt),
        .clause_len_i    (len),
        .all_lit_false_i (all_false),
        .cmax_lvl_i      (max_lvl),
        .csat_o          (t_sat),
        .unit_o          (t_unit),
        .conflict_o      (t_conf),
        .cmax_lvl_o      (t_lvl)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            sat_q  <= 1'b0;
            unit_q <= 1'b0;
            conf_q <= 1'b0;
            lvl_q  <= '0;
        end else begin
            sat_q  <= t_sat;
            unit_q <= t_unit;
            conf_q <= t_conf;
            lvl_q  <= t_lvl;
        end
    end

    // own slice of the status bus
    assign st.sat[ROW_ID]      = sat_q;
    assign st.unit[ROW_ID]     = unit_q;
    assign st.conflict[ROW_ID] = conf_q;
    assign st.lvl[ROW_ID]      = lvl_q;

    a_sat_excl_conf: assert property (
        @(posedge clk) disable iff (!rst)
        !(conf_q && sat_q)
    ) else $error("clause %0d both satisfied and conflicting", ROW_ID);

endmodule

//--- src/event_report.sv
module event_report #(
    parameter int NUM_CLAUSES = 8,
    parameter int WIDTH_LVL   = 8,
    localparam int CID_W      = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1
) (
    input  logic                 clk,
    input  logic                 rst,

    clause_status_if.report      st,

    output logic                 conflict_o,
    output logic [CID_W-1:0]     conflict_cid_o,
    output logic [WIDTH_LVL-1:0] conflict_lvl_o,
    output logic                 unit_o,
    output logic [CID_W-1:0]     unit_cid_o
);

    logic                 c_hit;
    logic [CID_W-1:0]     c_cid;
    logic [WIDTH_LVL-1:0] c_lvl;
    logic                 u_hit;
    logic [CID_W-1:0]     u_cid;

    // walk from the top so the lowest index wins
    always_comb begin
        c_hit = |st.conflict;
        c_cid = '0;
        c_lvl = '0;
        for (int i = NUM_CLAUSES - 1; i >= 0; i--) begin
            if (st.conflict[i]) begin
                c_cid = CID_W'(i);
                c_lvl = st.lvl[i];
            end
        end
    end

    always_comb begin
        u_hit = |st.unit;
        u_cid = '0;
        for (int i = NUM_CLAUSES - 1; i >= 0; i--) begin
            if (st.unit[i]) begin
                u_cid = CID_W'(i);
            end
        end
    end

    // ids and level read zero while nothing is reported
    always_ff @(posedge clk) begin
        if (!rst) begin
            conflict_o     <= 1'b0;
            conflict_cid_o <= '0;
            conflict_lvl_o <= '0;
            unit_o         <= 1'b0;
            unit_cid_o     <= '0;
        end else begin
            conflict_o     <= c_hit;
            conflict_cid_o <= c_cid;
            conflict_lvl_o <= c_lvl;
            unit_o         <= u_hit;
            unit_cid_o     <= u_cid;
        end
    end

    a_conf_cid_valid: assert property (
        @(posedge clk) disable iff (!rst)
        conflict_o |->
            ((NUM_CLAUSES'(1) << conflict_cid_o) & $past(st.conflict)) != '0
    ) else $error("conflict id %0d had no conflict", conflict_cid_o);

endmodule

//--- src/clause_engine_top.sv
module clause_engine_top import sat_pkg::*; #(
    parameter int NUM_VARS    = DEF_NUM_VARS,
    parameter int NUM_CLAUSES = DEF_NUM_CLAUSES,
    parameter int MAX_LEN     = DEF_MAX_LEN,
    parameter int WIDTH_LVL   = DEF_WIDTH_LVL,
    localparam int VAR_W      = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1,
    localparam int CID_W      = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1,
    localparam int SLOT_W     = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1
) (
    input  logic                 clk,
    input  logic                 rst,

    // assignment and backtrack strobe
    input  logic                 asg_valid_i,
    input  logic [VAR_W-1:0]     asg_var_i,
    input  logic                 asg_val_i,
    input  logic [WIDTH_LVL-1:0] asg_lvl_i,
    input  logic                 asg_clear_i,

    // clause loader strobe
    input  logic                 ld_valid_i,
    input  logic [CID_W-1:0]     ld_cid_i,
    input  logic [SLOT_W-1:0]    ld_slot_i,
    input  logic [VAR_W-1:0]     ld_var_i,
    input  logic                 ld_pol_i,
    input  logic                 ld_en_i,

    output logic                 conflict_o,
    output logic [CID_W-1:0]     conflict_cid_o,
    output logic [WIDTH_LVL-1:0] conflict_lvl_o,
    output logic                 unit_o,
    output logic [CID_W-1:0]     unit_cid_o
);

    var_state_if #(
        .NUM_VARS  (NUM_VARS),
        .WIDTH_LVL (WIDTH_LVL)
    ) vs_if ();

    clause_status_if #(
        .NUM_CLAUSES (NUM_CLAUSES),
        .WIDTH_LVL   (WIDTH_LVL)
    ) st_if ();

    assign_table #(
        .NUM_VARS  (NUM_VARS),
        .WIDTH_LVL (WIDTH_LVL)
    ) i_assign_table (
        .clk         (clk),
        .rst         (rst),
        .asg_valid_i (asg_valid_i),
        .asg_var_i   (asg_var_i),
        .asg_val_i   (asg_val_i),
        .asg_lvl_i   (asg_lvl_i),
        .asg_clear_i (asg_clear_i),
        .vs          (vs_if.tbl)
    );

    for (genvar r = 0; r < NUM_CLAUSES; r++) begin : g_row
        clause_row #(
            .NUM_VARS    (NUM_VARS),
            .NUM_CLAUSES (NUM_CLAUSES),
            .MAX_LEN     (MAX_LEN),
            .WIDTH_LVL   (WIDTH_LVL),
            .ROW_ID      (r)
        ) i_clause_row (
            .clk        (clk),
            .rst        (rst),
            .ld_valid_i (ld_valid_i),
            .ld_cid_i   (ld_cid_i),
            .ld_slot_i  (ld_slot_i),
            .ld_var_i   (ld_var_i),
            .ld_pol_i   (ld_pol_i),
            .ld_en_i    (ld_en_i),
            .vs         (vs_if.reader),
            .st         (st_if.row)
        );
    end

    event_report #(
        .NUM_CLAUSES (NUM_CLAUSES),
        .WIDTH_LVL   (WIDTH_LVL)
    ) i_event_report (
        .clk            (clk),
        .rst            (rst),
        .st             (st_if.report),
        .conflict_o     (conflict_o),
        .conflict_cid_o (conflict_cid_o),
        .conflict_lvl_o (conflict_lvl_o),
        .unit_o         (unit_o),
        .unit_cid_o     (unit_cid_o)
    );

endmodule

//--- dv/clause_engine_tb.sv
module clause_engine_tb
    import sat_pkg::*;
();

    localparam int NV     = DEF_NUM_VARS;
    localparam int NC     = DEF_NUM_CLAUSES;
    localparam int ML     = DEF_MAX_LEN;
    localparam int WL     = DEF_WIDTH_LVL;
    localparam int VW     = $clog2(NV);
    localparam int CW     = $clog2(NC);
    localparam int SW     = $clog2(ML);
    // {conflict, conflict id, conflict level, unit, unit id}
    localparam int RES_W  = 2 * CW + WL + 2;
    localparam int N_RAND = 400;
    localparam int N_CYC  = 3 + 20 + 3 * N_RAND + 3;

    logic clk;
    logic rst;
    logic asg_valid;
    logic [VW-1:0] asg_var;
    logic asg_val;
    logic [WL-1:0] asg_lvl;
    logic asg_clear;
    logic ld_valid;
    logic [CW-1:0] ld_cid;
    logic [SW-1:0] ld_slot;
    logic [VW-1:0] ld_var;
    logic ld_pol;
    logic ld_en;
    logic conflict_o;
    logic [CW-1:0] conflict_cid_o;
    logic [WL-1:0] conflict_lvl_o;
    logic unit_o;
    logic [CW-1:0] unit_cid_o;

    // mirror of the assignment table and the clause rows
    logic m_asg [NV];
    logic m_val [NV];
    logic [WL-1:0] m_lvl [NV];
    logic m_en [NC][ML];
    logic [VW-1:0] m_var [NC][ML];
    logic m_pol [NC][ML];

    // pending loader words {cid, slot, var, pol, en}
    logic [CW+SW+VW+1:0] ld_q [$];
    logic [RES_W-1:0] exp_pipe [2];

    int errors;
    int checks;
    int n_conf;
    int n_unit;

    clause_engine_top #(
        .NUM_VARS    (NV),
        .NUM_CLAUSES (NC),
        .MAX_LEN     (ML),
        .WIDTH_LVL   (WL)
    ) i_clause_engine_top (
        .clk            (clk),
        .rst            (rst),
        .asg_valid_i    (asg_valid),
        .asg_var_i      (asg_var),
        .asg_val_i      (asg_val),
        .asg_lvl_i      (asg_lvl),
        .asg_clear_i    (asg_clear),
        .ld_valid_i     (ld_valid),
        .ld_cid_i       (ld_cid),
        .ld_slot_i      (ld_slot),
        .ld_var_i       (ld_var),
        .ld_pol_i       (ld_pol),
        .ld_en_i        (ld_en),
        .conflict_o     (conflict_o),
        .conflict_cid_o (conflict_cid_o),
        .conflict_lvl_o (conflict_lvl_o),
        .unit_o         (unit_o),
        .unit_cid_o     (unit_cid_o)
    );

    always #5 clk = ~clk;

    // classify every clause of the mirror and pick the lowest ids
    function automatic logic [RES_W-1:0] expected_result();
        logic          conf_hit;
        logic [CW-1:0] conf_cid;
        logic [WL-1:0] conf_lvl;
        logic          unit_hit;
        logic [CW-1:0] unit_cid;
        logic          sat;
        logic [VW-1:0] v;
        logic [WL-1:0] hi_lvl;
        int            n_free;
        int            n_false;
        int            n_lits;
        conf_hit = 1'b0;
        conf_cid = '0;
        conf_lvl = '0;
        unit_hit = 1'b0;
        unit_cid = '0;
        for (int c = 0; c < NC; c++) begin
            sat     = 1'b0;
            hi_lvl  = '0;
            n_free  = 0;
            n_false = 0;
            n_lits  = 0;
            for (int k = 0; k < ML; k++) begin
                v = m_var[c][k];
                if (m_en[c][k]) begin
                    n_lits++;
                    if (!m_asg[v]) begin
                        n_free++;
                    end else if (m_val[v] == m_pol[c][k]) begin
                        sat = 1'b1;
                    end else begin
                        n_false++;
                        if (m_lvl[v] > hi_lvl) begin
                            hi_lvl = m_lvl[v];
                        end
                    end
                end
            end
            if (!conf_hit && n_lits != 0 && n_false == n_lits) begin
                conf_hit = 1'b1;
                conf_cid = CW'(c);
                conf_lvl = hi_lvl;
            end
            if (!unit_hit && !sat && n_free == 1) begin
                unit_hit = 1'b1;
                unit_cid = CW'(c);
            end
        end
        return {conf_hit, conf_cid, conf_lvl, unit_hit, unit_cid};
    endfunction

    task automatic compare_outputs(input logic [RES_W-1:0] exp_r);
        logic          e_conf;
        logic [CW-1:0] e_ccid;
        logic [WL-1:0] e_clvl;
        logic          e_unit;
        logic [CW-1:0] e_ucid;
        {e_conf, e_ccid, e_clvl, e_unit, e_ucid} = exp_r;
        checks++;
        assert (conflict_o === e_conf) else begin
            errors++;
            $display("FAIL conflict_o got %h expected %h at %0t", conflict_o, e_conf, $time);
        end
        assert (conflict_cid_o === e_ccid) else begin
            errors++;
            $display("FAIL conflict_cid_o got %h expected %h at %0t",
                     conflict_cid_o, e_ccid, $time);
        end
        assert (conflict_lvl_o === e_clvl) else begin
            errors++;
            $display("FAIL conflict_lvl_o got %h expected %h at %0t",
                     conflict_lvl_o, e_clvl, $time);
        end
        assert (unit_o === e_unit) else begin
            errors++;
            $display("FAIL unit_o got %h expected %h at %0t", unit_o, e_unit, $time);
        end
        assert (unit_cid_o === e_ucid) else begin
            errors++;
            $display("FAIL unit_cid_o got %h expected %h at %0t", unit_cid_o, e_ucid, $time);
        end
    endtask

    // random clause of 1 to ML slots, now and then with a gap
    task automatic queue_clause();
        int            len;
        logic [CW-1:0] c;
        c   = CW'($urandom_range(NC - 1));
        len = $urandom_range(ML, 1);
        for (int k = 0; k < len; k++) begin
            ld_q.push_back({c, SW'(k), VW'($urandom_range(NV - 1)), 1'($urandom_range(1)),
                            1'($urandom_range(9) != 0)});
        end
    endtask

    // one clock: check the result due now, then drive and mirror new strobes
    task automatic run_cycle(input int p_ld, input int p_asg, input int p_clr,
                             input bit falsify);
        logic [CW-1:0] l_cid;
        logic [SW-1:0] l_slot;
        logic [VW-1:0] l_var;
        logic          l_pol;
        logic          l_en;
        int            c;
        int            k;
        @(negedge clk);
        compare_outputs(exp_pipe[1]);
        exp_pipe[1] = exp_pipe[0];
        exp_pipe[0] = expected_result();
        if (exp_pipe[0][RES_W-1]) begin
            n_conf++;
        end
        if (exp_pipe[0][CW]) begin
            n_unit++;
        end

        if (ld_q.size() == 0 && $urandom_range(99) < p_ld) begin
            queue_clause();
        end
        ld_valid = 1'b0;
        ld_cid   = CW'($urandom());
        ld_slot  = SW'($urandom());
        ld_var   = VW'($urandom());
        ld_pol   = 1'($urandom());
        ld_en    = 1'($urandom());
        if (ld_q.size() != 0) begin
            {l_cid, l_slot, l_var, l_pol, l_en} = ld_q.pop_front();
            ld_valid = 1'b1;
            ld_cid   = l_cid;
            ld_slot  = l_slot;
            ld_var   = l_var;
            ld_pol   = l_pol;
            ld_en    = l_en;
            // slot 0 starts the clause over
            if (l_slot == '0) begin
                for (int s = 0; s < ML; s++) begin
                    m_en[l_cid][s] = 1'b0;
                end
            end
            m_en[l_cid][l_slot]  = l_en;
            m_var[l_cid][l_slot] = l_var;
            m_pol[l_cid][l_slot] = l_pol;
        end

        asg_valid = 1'b0;
        asg_var   = VW'($urandom());
        asg_val   = 1'($urandom());
        asg_lvl   = WL'($urandom());
        asg_clear = 1'b0;
        if ($urandom_range(99) < p_asg) begin
            asg_valid = 1'b1;
            asg_clear = ($urandom_range(99) < p_clr);
            if (falsify) begin
                c = $urandom_range(NC - 1);
                k = $urandom_range(ML - 1);
                // push a present literal towards false
                if (m_en[c][k]) begin
                    asg_var = m_var[c][k];
                    asg_val = !m_pol[c][k];
                end
            end
            if (asg_clear) begin
                m_asg[asg_var] = 1'b0;
                m_lvl[asg_var] = '0;
            end else begin
                m_asg[asg_var] = 1'b1;
                m_val[asg_var] = asg_val;
                m_lvl[asg_var] = asg_lvl;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h689a_abe0));
        errors    = 0;
        checks    = 0;
        n_conf    = 0;
        n_unit    = 0;
        clk       = 1'b0;
        rst       = 1'b0;
        asg_valid = 1'b0;
        asg_var   = '0;
        asg_val   = 1'b0;
        asg_lvl   = '0;
        asg_clear = 1'b0;
        ld_valid  = 1'b0;
        ld_cid    = '0;
        ld_slot   = '0;
        ld_var    = '0;
        ld_pol    = 1'b0;
        ld_en     = 1'b0;
        for (int v = 0; v < NV; v++) begin
            m_asg[v] = 1'b0;
            m_val[v] = 1'b0;
            m_lvl[v] = '0;
        end
        for (int c = 0; c < NC; c++) begin
            for (int k = 0; k < ML; k++) begin
                m_en[c][k]  = 1'b0;
                m_var[c][k] = '0;
                m_pol[c][k] = 1'b0;
            end
        end

        repeat (3) @(negedge clk);
        rst = 1'b1;
        compare_outputs('0);
        exp_pipe[0] = expected_result();
        exp_pipe[1] = exp_pipe[0];

        // no clauses yet, assignments alone must stay silent
        for (int i = 0; i < 20; i++) begin
            run_cycle(0, 60, 0, 1'b0);
            assert (!conflict_o && !unit_o) else begin
                errors++;
                $display("a clause was reported while no clause was loaded at %0t", $time);
            end
        end
        for (int i = 0; i < N_RAND; i++) begin
            run_cycle(40, 50, 10, 1'b0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            run_cycle(10, 70, 15, 1'b1);
        end
        // both strobes every cycle
        for (int i = 0; i < N_RAND; i++) begin
            run_cycle(100, 100, 30, 1'($urandom_range(1)));
        end
        repeat (3) begin
            run_cycle(0, 0, 0, 1'b0);
        end

        assert (n_conf > 0) else begin
            errors++;
            $display("random stimulus never produced a conflicting clause");
        end
        assert (n_unit > 0) else begin
            errors++;
            $display("random stimulus never produced a unit clause");
        end
        $display("checks %0d, errors %0d, conflict cycles %0d, unit cycles %0d",
                 checks, errors, n_conf, n_unit);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(10 * (N_CYC + 50));
        $display("checks %0d, errors %0d, run stopped by the watchdog", checks, errors);
        $display("tests failed");
        $finish;
    end

endmodule

//--- all.f
src/sat_pkg.sv
src/var_state_if.sv
src/assign_table.sv
src/lit_cell.sv
src/terminal_cell.sv
src/clause_row.sv
src/event_report.sv
src/clause_engine_top.sv
dv/clause_engine_tb.sv

//--- Makefile
TOP = clause_engine_tb

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	! grep -q "tests failed" sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
